// ==== hdl/hist_pkg.sv ====
`default_nettype none

package hist_pkg;

    // time-bin addressing
    localparam int BIN_W   = 4;
    localparam int BIN_NUM = 16;

    // per-bin counter, saturates at all ones
    localparam int COUNT_W = 4;

    // frame geometry
    // hits per pixel, pixels per acquisition, acquisitions per frame
    localparam int DATA_NUM  = 2;
    localparam int PIXEL_NUM = 4;
    localparam int ACQ_NUM   = 3;

    // widths of the nested frame counters
    localparam int DATA_CNT_W = $clog2(DATA_NUM);
    localparam int PIX_CNT_W  = $clog2(PIXEL_NUM);
    localparam int ACQ_CNT_W  = $clog2(ACQ_NUM);

    // strobe to write-back of one increment, in cycles
    localparam int RMW_LATENCY = 2;

    // bin address and bin count
    typedef logic [BIN_W-1:0]   bin_t;
    typedef logic [COUNT_W-1:0] count_t;

    // readout FSM
    typedef enum logic {
        IDLE,
        SCAN
    } readout_state_t;

endpackage

`default_nettype wire

// ==== hdl/hist_frame_counter.sv ====
`default_nettype none

module hist_frame_counter (
    input  wire  clk,
    input  wire  res,
    input  wire  logic hit_valid,
    output logic frame_done,
    output logic active_bank
);

    import hist_pkg::*;

    // nested position of the current hit inside the frame
    logic [DATA_CNT_W-1:0] data_cnt;
    logic [PIX_CNT_W-1:0]  pix_cnt;
    logic [ACQ_CNT_W-1:0]  acq_cnt;

    // wrap flags of each level
    logic data_last;
    logic pix_last;
    logic acq_last;

    // hit that closes the frame
    logic frame_end;

    // frame end delayed until the last write-back is done
    logic [RMW_LATENCY:0] done_sr;

    assign data_last = (data_cnt == DATA_CNT_W'(DATA_NUM - 1));
    assign pix_last  = (pix_cnt == PIX_CNT_W'(PIXEL_NUM - 1));
    assign acq_last  = (acq_cnt == ACQ_CNT_W'(ACQ_NUM - 1));
    assign frame_end = hit_valid & data_last & pix_last & acq_last;

    // inputs -> pixels -> acquisitions, only on a hit
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            data_cnt <= '0;
            pix_cnt  <= '0;
            acq_cnt  <= '0;
        end else if (hit_valid) begin
            if (data_last) begin
                data_cnt <= '0;
                if (pix_last) begin
                    pix_cnt <= '0;
                    // all three wrap together at frame end
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                data_cnt <= data_cnt + 1'b1;
            end
        end
    end

    // bank swap on the closing hit, the next hit already lands in the new bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active_bank <= 1'b0;
        end else if (frame_end) begin
            active_bank <= ~active_bank;
        end
    end

    // one stage per pipeline step plus the output stage
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            done_sr <= '0;
        end else begin
            done_sr <= {done_sr[RMW_LATENCY-1:0], frame_end};
        end
    end

    assign frame_done = done_sr[RMW_LATENCY];

endmodule

`default_nettype wire

// ==== hdl/hist_bin_ram.sv ====
`default_nettype none

module hist_bin_ram (
    input  wire  clk,
    input  wire  res,
    input  wire  logic hit_valid,
    input  wire  hist_pkg::bin_t hit_bin,
    input  wire  logic active_bank,
    input  wire  logic clr_en,
    input  wire  hist_pkg::bin_t clr_bin,
    output hist_pkg::count_t clr_count
);

    import hist_pkg::*;

    // two banks, one filling while the other drains
    count_t mem [2][BIN_NUM];

    // bank that is read out and cleared
    logic rd_bank;

    // stage one of the increment pipe
    logic   s1_valid;
    logic   s1_bank;
    bin_t   s1_bin;
    count_t s1_count;

    // saturated sum of stage one, written at the next edge
    count_t s1_next;

    // count seen by a new hit, from memory or forwarded
    count_t hit_count;
    logic   fwd_hit;

    assign rd_bank = ~active_bank;

    // hold at all ones instead of wrapping to zero
    assign s1_next = (s1_count == '1) ? s1_count : s1_count + 1'b1;

    // same entry still being written, memory is one step behind
    assign fwd_hit = s1_valid
                   && (s1_bank == active_bank)
                   && (s1_bin == hit_bin);

    assign hit_count = fwd_hit ? s1_next : mem[active_bank][hit_bin];

    // only the valid flag is control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= hit_valid;
        end
    end

    // bank travels with its hit
    // a toggle between read and write does not move it
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            s1_bank  <= active_bank;
            s1_bin   <= hit_bin;
            s1_count <= hit_count;
        end
    end

    // increment write-back and read-and-clear
    // both sides never meet in the same bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < BIN_NUM; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            if (s1_valid) begin
                mem[s1_bank][s1_bin] <= s1_next;
            end
            // zero as it is read, bank is empty for the next frame
            if (clr_en) begin
                mem[rd_bank][clr_bin] <= '0;
            end
        end
    end

    // combinational read of the finished bank
    assign clr_count = mem[rd_bank][clr_bin];

endmodule

`default_nettype wire

// ==== hdl/hist_readout.sv ====
`default_nettype none

module hist_readout (
    input  wire  clk,
    input  wire  res,
    input  wire  logic frame_done,
    output logic clr_en,
    output hist_pkg::bin_t clr_bin,
    input  wire  hist_pkg::count_t clr_count,
    output logic rd_valid,
    output hist_pkg::bin_t rd_bin,
    output hist_pkg::count_t rd_count
);

    import hist_pkg::*;

    readout_state_t state;

    // scan pointer on the last bin
    logic scan_last;

    assign scan_last = (clr_bin == BIN_W'(BIN_NUM - 1));

    // every scan cycle reads one bin and clears it
    assign clr_en = (state == SCAN);

    // scan sequencer
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= IDLE;
            clr_bin <= '0;
        end else begin
            case (state)
                IDLE: begin
                    clr_bin <= '0;
                    if (frame_done) begin
                        state <= SCAN;
                    end
                end
                SCAN: begin
                    // wraps back to bin 0 after the last one
                    clr_bin <= clr_bin + 1'b1;
                    if (scan_last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // one beat per scanned bin
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= clr_en;
        end
    end

    // stream payload, sampled before the bin is zeroed
    always_ff @(posedge clk) begin
        if (clr_en) begin
            rd_bin   <= clr_bin;
            rd_count <= clr_count;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hist_top.sv ====
`default_nettype none

module hist_top (
    input  wire  clk,
    input  wire  res,
    input  wire  logic hit_valid,
    input  wire  hist_pkg::bin_t hit_bin,
    output logic frame_done,
    output logic frame_bank,
    output logic rd_valid,
    output hist_pkg::bin_t rd_bin,
    output hist_pkg::count_t rd_count
);

    import hist_pkg::*;

    // bank taking new hits
    logic active_bank;

    // readout to memory
    logic   clr_en;
    bin_t   clr_bin;
    count_t clr_count;

    // frame geometry and bank select
    hist_frame_counter u_frame_counter (
        .clk         (clk),
        .res         (res),
        .hit_valid   (hit_valid),
        .frame_done  (frame_done),
        .active_bank (active_bank)
    );

    // histogram storage
    hist_bin_ram u_bin_ram (
        .clk         (clk),
        .res         (res),
        .hit_valid   (hit_valid),
        .hit_bin     (hit_bin),
        .active_bank (active_bank),
        .clr_en      (clr_en),
        .clr_bin     (clr_bin),
        .clr_count   (clr_count)
    );

    // drains the finished bank after each frame
    hist_readout u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .clr_en     (clr_en),
        .clr_bin    (clr_bin),
        .clr_count  (clr_count),
        .rd_valid   (rd_valid),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

    // the bank being read is the one not taking hits
    assign frame_bank = ~active_bank;

endmodule

`default_nettype wire

// ==== tests/tb_hist.sv ====
`default_nettype none

module tb_hist;

    timeunit 1ns;
    timeprecision 100ps;

    import hist_pkg::*;

    localparam int HALF_PERIOD  = 4;
    localparam int CLK_PERIOD   = 2 * HALF_PERIOD;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_HITS   = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int COUNT_MAX    = (1 << COUNT_W) - 1;
    localparam int NUM_FRAMES   = 6;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_LIMIT  = 4 * BIN_NUM;
    // worst case hit time of all frames, plus reset, readouts and slack
    localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_HITS * (MAX_GAP + 1) * CLK_PERIOD
                                + (RESET_CYCLES + 40 + NUM_FRAMES * (BIN_NUM + 4)) * CLK_PERIOD;

    logic   clk;
    logic   res;
    logic   hit_valid;
    bin_t   hit_bin;
    logic   frame_done;
    logic   frame_bank;
    logic   rd_valid;
    bin_t   rd_bin;
    count_t rd_count;

    // every bin sent, in order, frame after frame
    int sent_bins [NUM_FRAMES * FRAME_HITS];
    int hits_sent;

    // compare side bookkeeping
    int frames_done;
    int frame_rd;
    int beat_idx;
    int beats_seen;
    int errors;
    int missing;

    // hits seen on the inputs and cycles left until frame_done is due
    int hits_seen;
    int done_wait;

    // position inside the readout stream, BIN_NUM when no stream runs
    int stream_pos;

    logic [31:0] rng;

    hist_top i_dut (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .frame_done (frame_done),
        .frame_bank (frame_bank),
        .rd_valid   (rd_valid),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

    always #HALF_PERIOD clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // reference model, counts one bin of one frame and holds at the max
    function automatic int expected_count(input int frame, input int bin);
        int cnt;
        cnt = 0;
        for (int i = 0; i < FRAME_HITS; i++) begin
            if (sent_bins[frame * FRAME_HITS + i] == bin && cnt < COUNT_MAX) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic pick_random(input int range, output int value);
        rng = xorshift32(rng);
        value = int'(rng % range);
    endtask

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send_hit(input int bin, input int gap);
        hit_valid = 1'b1;
        hit_bin = bin_t'(bin);
        sent_bins[hits_sent] = bin;
        hits_sent++;
        @(posedge clk);
        #1;
        hit_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    // compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        // nothing may come out before the first hit
        if (hits_sent == 0) begin
            assert (!rd_valid && !frame_done) else begin
                $display("** Error at %0t: output activity before any hit", $time);
                errors++;
            end
        end
        // pulse exactly RMW_LATENCY + 1 cycles after every closing hit
        assert (frame_done == (done_wait == 0)) else begin
            $display("** Error at %0t: frame_done is %0b after %0d hits",
                     $time, frame_done, hits_seen);
            errors++;
        end
        // one beat per cycle, starting two cycles after frame_done
        assert (rd_valid == (stream_pos >= 0 && stream_pos < BIN_NUM)) else begin
            $display("** Error at %0t: rd_valid is %0b at stream position %0d",
                     $time, rd_valid, stream_pos);
            errors++;
        end
        if (done_wait >= 0) begin
            done_wait--;
        end
        if (hit_valid) begin
            hits_seen++;
            if (hits_seen % FRAME_HITS == 0) begin
                done_wait = RMW_LATENCY;
            end
        end
        if (stream_pos < BIN_NUM) begin
            stream_pos++;
        end
        if (frame_done) begin
            frames_done++;
            stream_pos = -1;
        end
        if (rd_valid) begin
            if (frame_rd >= frames_done || frame_rd >= NUM_FRAMES) begin
                $display("unexpected readout beat at %0t with no finished frame", $time);
                errors++;
            end else begin
                if (beat_idx == 0) begin
                    // banks alternate, frame 0 is read from bank 0
                    assert (frame_bank == frame_rd[0]) else begin
                        $display("** Error at %0t: frame %0d read from bank %0d",
                                 $time, frame_rd, frame_bank);
                        errors++;
                    end
                end
                assert (rd_bin == bin_t'(beat_idx)) else begin
                    $display("** Error at %0t: frame %0d beat %0d has bin %0d",
                             $time, frame_rd, beat_idx, rd_bin);
                    errors++;
                end
                assert (int'(rd_count) == expected_count(frame_rd, beat_idx)) else begin
                    $display("** Error at %0t: frame %0d bin %0d count %0d, expected %0d",
                             $time, frame_rd, beat_idx, rd_count,
                             expected_count(frame_rd, beat_idx));
                    errors++;
                end
                beats_seen++;
                beat_idx++;
                if (beat_idx == BIN_NUM) begin
                    beat_idx = 0;
                    frame_rd++;
                end
            end
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    // stimulus
    initial begin
        int bin;
        int gap;
        int run_len;
        int n;
        int wait_cycles;
        clk = 1'b0;
        res = 1'b0;
        hit_valid = 1'b0;
        hit_bin = '0;
        hits_sent = 0;
        frames_done = 0;
        frame_rd = 0;
        beat_idx = 0;
        beats_seen = 0;
        errors = 0;
        missing = 0;
        hits_seen = 0;
        done_wait = -1;
        stream_pos = BIN_NUM;
        rng = 32'h3215;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        res = 1'b1;
        // quiet stretch, compare process checks the outputs stay low
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        // frame 0, random bins back to back
        for (int i = 0; i < FRAME_HITS; i++) begin
            pick_random(BIN_NUM, bin);
            send_hit(bin, 0);
        end
        // frame 1, runs into one bin for the forwarding path
        n = 0;
        while (n < FRAME_HITS) begin
            pick_random(BIN_NUM, bin);
            pick_random(4, run_len);
            for (int j = 0; j <= run_len && n < FRAME_HITS; j++) begin
                send_hit(bin, 0);
                n++;
            end
        end
        // frame 2, all hits in one bin, count must hold at max
        pick_random(BIN_NUM, bin);
        for (int i = 0; i < FRAME_HITS; i++) begin
            send_hit(bin, 0);
        end
        // remaining frames with random idle gaps
        for (int f = 3; f < NUM_FRAMES; f++) begin
            for (int i = 0; i < FRAME_HITS; i++) begin
                pick_random(BIN_NUM, bin);
                pick_random(MAX_GAP + 1, gap);
                send_hit(bin, gap);
            end
        end
        // drain the last readout, bounded
        wait_cycles = 0;
        while (frame_rd < NUM_FRAMES && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        repeat (4) @(posedge clk);
        missing = NUM_FRAMES * BIN_NUM - beats_seen;
        $display("errors: %0d, missing beats: %0d, frames: %0d of %0d",
                 errors, missing, frames_done, NUM_FRAMES);
        if (errors == 0 && missing == 0 && frames_done == NUM_FRAMES) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/hist_pkg.sv
hdl/hist_frame_counter.sv
hdl/hist_bin_ram.sv
hdl/hist_readout.sv
hdl/hist_top.sv
tests/tb_hist.sv

// ==== Makefile ====
# Verilator build and run for the histogram testbench

VERILATOR ?= verilator
TOP       ?= tb_hist
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(BUILD_DIR)
